/* uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// **************************************************************************
// clock rates and serial timing
// **************************************************************************
`define UART_CLK_HZ      32'd200_000_000      // 5 ns clk_uart
`define UART_BAUD        32'd25_000_000       // kept fast so frames stay short in sim
`define UART_DIV         ((`UART_CLK_HZ / `UART_BAUD) - 1)  // clk_uart cycles per bit, minus one

// byte queue depth is 2**TXQ_DEPTH_LOG2
`define TXQ_DEPTH_LOG2   4

// crossing pulse widths
// request is held REQ_STRETCH clk_bus cycles, so the clk_uart period must
// stay under REQ_STRETCH bus periods; done is held DONE_STRETCH clk_uart
// cycles and must cover more than two bus periods
`define REQ_STRETCH      5
`define DONE_STRETCH     4

`endif

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // **********************************************************************
    // transmitter FSM
    // **********************************************************************
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,   // line high, waiting for request
        TX_LOAD  = 2'd1,   // start bit goes out
        TX_SHIFT = 2'd2,   // counting out each bit
        TX_HOLD  = 2'd3    // frame done, wait for request to drop
    } tx_state_e;

    // **********************************************************************
    // data carriers
    // **********************************************************************

    // one byte with a strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_wr_t;

    // serial frame, start bit at bit 0 so it leaves first
    typedef struct packed {
        logic       stop;
        logic [7:0] data;
        logic       start;
    } tx_frame_t;

endpackage

`default_nettype wire

/* tx_arbiter.sv */
`default_nettype none

module tx_arbiter (
    input  logic               clk_bus,
    input  logic               rst_n,
    input  uart_pkg::byte_wr_t port_a,
    input  uart_pkg::byte_wr_t port_b,
    input  logic               full,
    output uart_pkg::byte_wr_t wr_push,
    output logic               overrun_a,
    output logic               overrun_b,
    output logic               pending
);

    // index 0 is port a, index 1 is port b
    uart_pkg::byte_wr_t [1:0] strobe;
    logic [1:0]               hold_vld;
    logic [1:0][7:0]          hold_data;
    logic [1:0]               take;      // holding byte goes into the FIFO
    logic [1:0]               accept;    // strobe lands in holding
    logic [1:0]               drop;      // strobe lost
    logic                     last_a;    // port a had the last grant
    logic                     grant_b;

    assign strobe = {port_b, port_a};

    // **********************************************************************
    // round-robin grant
    // **********************************************************************
    assign grant_b = hold_vld[1] && (!hold_vld[0] || last_a);

    assign take[1] = grant_b && !full;
    assign take[0] = hold_vld[0] && !grant_b && !full;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            accept[i] = strobe[i].valid && (!hold_vld[i] || take[i]);
            drop[i]   = strobe[i].valid && hold_vld[i] && !take[i];
        end
    end

    always_comb begin
        wr_push.valid = |take;
        wr_push.data  = grant_b ? hold_data[1] : hold_data[0];
    end

    assign pending = |hold_vld;

    // **********************************************************************
    // holding registers and overrun
    // **********************************************************************
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            hold_vld  <= '0;
            last_a    <= 1'b1;   // b wins the first tie
            overrun_a <= 1'b0;
            overrun_b <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (accept[i]) begin
                    hold_vld[i] <= 1'b1;
                end else if (take[i]) begin
                    hold_vld[i] <= 1'b0;
                end
            end
            if (|take) begin
                last_a <= take[0];
            end
            if (drop[0]) begin
                overrun_a <= 1'b1;   // sticky
            end
            if (drop[1]) begin
                overrun_b <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        for (int i = 0; i < 2; i++) begin
            if (accept[i]) begin
                hold_data[i] <= strobe[i].data;
            end
        end
    end

    // the FIFO never sees a push while it is full
    a_push_not_full : assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        wr_push.valid |-> !full
    ) else $error("push while FIFO full");

endmodule

`default_nettype wire

/* tx_fifo.sv */
`default_nettype none

`include "uart_consts.svh"

module tx_fifo (
    input  logic               clk_bus,
    input  logic               rst_n,
    input  uart_pkg::byte_wr_t wr_push,
    input  logic               tx_idle,
    output logic               full,
    output logic               empty,
    output uart_pkg::byte_wr_t tx_launch
);

    localparam int AW    = `TXQ_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    logic [7:0]  mem [DEPTH];
    logic [AW:0] wr_ptr;   // extra msb marks the wrap
    logic [AW:0] rd_ptr;
    logic        pop;

    // **********************************************************************
    // status
    // **********************************************************************
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // launch is the pop
    assign pop = !empty && tx_idle;

    always_comb begin
        tx_launch.valid = pop;
        tx_launch.data  = mem[rd_ptr[AW-1:0]];
    end

    // **********************************************************************
    // pointers and storage
    // **********************************************************************
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_push.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (wr_push.valid) begin
            mem[wr_ptr[AW-1:0]] <= wr_push.data;
        end
    end

    a_launch_idle : assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        tx_launch.valid |-> tx_idle
    ) else $error("launch while transmitter busy");

    // the transmitter drops idle on the next edge, so launches are single pulses
    a_launch_once : assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        tx_launch.valid |=> !tx_idle
    ) else $error("transmitter still idle after launch");

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

`include "uart_consts.svh"

module uart_tx (
    input  logic               clk_bus,
    input  logic               clk_uart,
    input  logic               rst_n,
    input  uart_pkg::byte_wr_t tx_launch,
    output logic               tx_idle,
    output logic               txd
);

    localparam int                REQ_W   = `REQ_STRETCH;
    localparam int                DONE_W  = `DONE_STRETCH;
    localparam int                BAUD_W  = $clog2(`UART_DIV + 1);
    localparam logic [BAUD_W-1:0] BAUD_TOP = BAUD_W'(`UART_DIV);

    // bus side
    logic [REQ_W-1:0]      req_sr;
    logic                  req_str;     // stretched request, crosses to clk_uart
    logic [7:0]            data_bus;    // held for the whole frame
    logic                  done_bus;
    logic                  done_bus_q;

    // uart side
    uart_pkg::tx_state_e   state;
    uart_pkg::tx_frame_t   frame;
    logic                  req_uart;
    logic [3:0]            bit_cnt;
    logic [BAUD_W-1:0]     baud_cnt;
    logic [DONE_W-1:0]     done_sr;
    logic                  done_uart;   // stretched done, crosses to clk_bus
    logic                  next_bit;

    // **********************************************************************
    // clk_bus side
    // **********************************************************************
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            tx_idle    <= 1'b1;
            req_sr     <= '0;
            req_str    <= 1'b0;
            done_bus   <= 1'b0;
            done_bus_q <= 1'b0;
        end else begin
            done_bus   <= done_uart;
            done_bus_q <= done_bus;
            req_str    <= |req_sr;   // one cycle behind the latch
            req_sr     <= req_sr << 1;
            if (tx_launch.valid && tx_idle) begin
                req_sr  <= REQ_W'(1);
                tx_idle <= 1'b0;
            end else if (done_bus_q && !done_bus) begin
                tx_idle <= 1'b1;   // falling edge of done
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (tx_launch.valid && tx_idle) begin
            data_bus <= tx_launch.data;
        end
    end

    // **********************************************************************
    // clk_uart side
    // **********************************************************************
    assign next_bit = (state == uart_pkg::TX_LOAD) ||
                      (state == uart_pkg::TX_SHIFT && baud_cnt == '0 && bit_cnt != 4'd0);

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state     <= uart_pkg::TX_IDLE;
            txd       <= 1'b1;
            req_uart  <= 1'b0;
            bit_cnt   <= 4'd0;
            baud_cnt  <= '0;
            done_sr   <= '0;
            done_uart <= 1'b0;
        end else begin
            req_uart  <= req_str;
            done_uart <= |done_sr;
            done_sr   <= done_sr << 1;
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (req_uart) begin
                        state <= uart_pkg::TX_LOAD;
                    end
                end
                uart_pkg::TX_LOAD: begin
                    txd      <= frame[0];   // start bit
                    bit_cnt  <= 4'd9;
                    baud_cnt <= BAUD_TOP;
                    state    <= uart_pkg::TX_SHIFT;
                end
                uart_pkg::TX_SHIFT: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else if (bit_cnt != 4'd0) begin
                        txd      <= frame[0];
                        bit_cnt  <= bit_cnt - 1'b1;
                        baud_cnt <= BAUD_TOP;
                    end else begin
                        txd     <= 1'b1;   // stop bit done
                        done_sr <= DONE_W'(1);
                        state   <= uart_pkg::TX_HOLD;
                    end
                end
                uart_pkg::TX_HOLD: begin
                    if (!req_uart) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_uart) begin
        if (state == uart_pkg::TX_IDLE && req_uart) begin
            frame <= '{stop: 1'b1, data: data_bus, start: 1'b0};
        end else if (next_bit) begin
            frame <= {1'b1, frame[9:1]};   // lsb first
        end
    end

    a_idle_line_high : assert property (
        @(posedge clk_uart) disable iff (!rst_n)
        state == uart_pkg::TX_IDLE |-> txd
    ) else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

/* uart_tx_top.sv */
`default_nettype none

module uart_tx_top (
    input  logic               clk_bus,
    input  logic               clk_uart,
    input  logic               rst_n,
    input  uart_pkg::byte_wr_t port_a,
    input  uart_pkg::byte_wr_t port_b,
    output logic               overrun_a,
    output logic               overrun_b,
    output logic               busy,
    output logic               txd
);

    uart_pkg::byte_wr_t wr_push;
    uart_pkg::byte_wr_t tx_launch;
    logic               full;
    logic               empty;
    logic               pending;
    logic               tx_idle;

    // **********************************************************************
    // bus side
    // **********************************************************************
    tx_arbiter u_arbiter (
        .clk_bus   (clk_bus),
        .rst_n     (rst_n),
        .port_a    (port_a),
        .port_b    (port_b),
        .full      (full),
        .wr_push   (wr_push),
        .overrun_a (overrun_a),
        .overrun_b (overrun_b),
        .pending   (pending)
    );

    tx_fifo u_fifo (
        .clk_bus   (clk_bus),
        .rst_n     (rst_n),
        .wr_push   (wr_push),
        .tx_idle   (tx_idle),
        .full      (full),
        .empty     (empty),
        .tx_launch (tx_launch)
    );

    // **********************************************************************
    // serial side
    // **********************************************************************
    uart_tx u_tx (
        .clk_bus   (clk_bus),
        .clk_uart  (clk_uart),
        .rst_n     (rst_n),
        .tx_launch (tx_launch),
        .tx_idle   (tx_idle),
        .txd       (txd)
    );

    // anything held, queued or on the wire
    assign busy = pending || !empty || !tx_idle;

endmodule

`default_nettype wire

/* tb_serial_sink.sv */
`default_nettype none

`include "uart_consts.svh"

module tb_serial_sink (
    input  logic       clk_uart,
    input  logic       rst_n,
    input  logic       txd,
    output logic [7:0] rx_data,
    output logic       rx_stb,
    output int         fault_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CYC  = `UART_DIV + 1;
    localparam int HALF_CYC = BIT_CYC / 2 - 1;   // first low sample to mid start bit

    logic [7:0] shift;

    initial begin
        rx_stb    = 1'b0;
        rx_data   = 8'h00;
        fault_cnt = 0;
        forever begin
            @(posedge clk_uart);
            rx_stb = 1'b0;
            if (rst_n && !txd) begin
                repeat (HALF_CYC) @(posedge clk_uart);
                if (txd) begin
                    fault_cnt++;
                    $display("sink: start bit too short at %0t", $time);
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (BIT_CYC) @(posedge clk_uart);
                        shift[i] = txd;   // lsb first
                    end
                    repeat (BIT_CYC) @(posedge clk_uart);
                    if (!txd) begin
                        fault_cnt++;
                        $display("sink: stop bit low after byte 0x%02h", shift);
                    end else begin
                        rx_data = shift;
                        rx_stb  = 1'b1;   // one clk_uart cycle wide
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_uart_tx_top.sv */
`default_nettype none

`include "uart_consts.svh"

module tb_uart_tx_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH    = 1 << `TXQ_DEPTH_LOG2;
    localparam int BYTE_CYC = 200;   // bus cycles, well over one frame

    logic               clk_bus;
    logic               clk_uart;
    logic               rst_n;
    uart_pkg::byte_wr_t port_a;
    uart_pkg::byte_wr_t port_b;
    logic               overrun_a;
    logic               overrun_b;
    logic               busy;
    logic               txd;
    logic [7:0]         rx_data;
    logic               rx_stb;
    int                 fault_cnt;

    logic [7:0] exp_q[$];
    logic [7:0] rx_q[$];
    logic [7:0] burst[$];
    logic [1:0] m_vld;   // model holding, index 0 is port a
    logic [7:0] m_data[2];
    logic       m_last_a;
    logic [1:0] m_ovr;
    int         errs;
    int         n_pass;
    int         n_fail;
    int         faults_seen;

    uart_tx_top dut (.*);
    tb_serial_sink u_sink (.*);

    initial begin
        clk_bus = 1'b0;
        forever #2 clk_bus = ~clk_bus;
    end

    initial begin
        clk_uart = 1'b0;
        forever #2.5 clk_uart = ~clk_uart;
    end

    always @(posedge rx_stb) begin
        rx_q.push_back(rx_data);
    end

    // **********************************************************************
    // checks and reference model
    // **********************************************************************
    function automatic void check_val(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s: expected 0x%0h got 0x%0h", name, expected, actual);
            errs++;
        end
    endfunction

    function automatic void check_true(input bit ok, input string what);
        assert (ok) else begin
            $display("%s", what);
            errs++;
        end
    endfunction

    // one arbiter edge; FIFO counted full from pushed minus received
    function automatic void model_step(input logic sa, input logic [7:0] da,
                                       input logic sb, input logic [7:0] db);
        logic [1:0] stb;
        logic [1:0] take;
        logic       full_m;
        logic       grant_b;
        stb     = {sb, sa};
        full_m  = (exp_q.size() - rx_q.size()) >= DEPTH;
        grant_b = m_vld[1] && (!m_vld[0] || m_last_a);
        take[1] = grant_b && !full_m;
        take[0] = m_vld[0] && !grant_b && !full_m;
        if (take != 2'b00) begin
            exp_q.push_back(m_data[take[1]]);
            m_last_a = take[0];
        end
        for (int i = 0; i < 2; i++) begin
            if (stb[i] && m_vld[i] && !take[i]) begin
                m_ovr[i] = 1'b1;   // byte lost
            end else if (stb[i]) begin
                m_vld[i]  = 1'b1;
                m_data[i] = (i == 0) ? da : db;
            end else if (take[i]) begin
                m_vld[i] = 1'b0;
            end
        end
    endfunction

    function automatic void check_stream();
        check_val("byte count", exp_q.size(), rx_q.size());
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check_val($sformatf("txd byte %0d", i), exp_q[i], rx_q[i]);
        end
    endfunction

    task automatic drive_cycle(input logic sa, input logic [7:0] da, input logic sb,
                               input logic [7:0] db, input bit modelled);
        @(posedge clk_bus);
        port_a <= '{valid: sa, data: da};
        port_b <= '{valid: sb, data: db};
        if (modelled) begin
            model_step(sa, da, sb, db);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 8'h00, 1'b0, 8'h00, 1'b1);
    endtask

    task automatic wait_drained(input int n, input int limit);
        int cyc;
        cyc = 0;
        while ((rx_q.size() < n || busy) && cyc < limit) begin
            @(posedge clk_bus);
            cyc++;
        end
        check_true(cyc < limit, $sformatf("timeout after %0d cycles with %0d of %0d bytes",
                                          limit, rx_q.size(), n));
    endtask

    task automatic end_test(input string name);
        check_val("overrun_a", m_ovr[0], overrun_a);
        check_val("overrun_b", m_ovr[1], overrun_b);
        check_true(fault_cnt == faults_seen, "framing fault seen on txd");
        faults_seen = fault_cnt;
        if (errs == 0) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, errs);
        end
        errs = 0;
        exp_q.delete();
        rx_q.delete();
    endtask

    // **********************************************************************
    // test sequence
    // **********************************************************************
    initial begin
        logic [7:0] d;
        int         bi;
        int         cyc;
        bit         in_order;
        void'($urandom(57944));
        rst_n       = 1'b0;
        port_a      = '0;
        port_b      = '0;
        m_vld       = '0;
        m_last_a    = 1'b1;   // b wins the first tie
        m_ovr       = '0;
        errs        = 0;
        n_pass      = 0;
        n_fail      = 0;
        faults_seen = 0;
        repeat (10) @(posedge clk_bus);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk_bus);

        check_val("txd", 1, txd);
        check_val("busy", 0, busy);
        end_test("reset");

        drive_cycle(1'b1, 8'($urandom), 1'b0, 8'h00, 1'b1);
        idle_cycles(3);
        wait_drained(exp_q.size(), 2 * BYTE_CYC);
        check_stream();
        end_test("single");

        for (int k = 0; k < 6; k++) begin
            drive_cycle(1'b1, 8'($urandom), 1'b1, 8'($urandom), 1'b1);
            idle_cycles(1 + $urandom_range(2));
        end
        idle_cycles(3);
        wait_drained(exp_q.size(), 14 * BYTE_CYC);
        check_stream();
        end_test("pairs");

        for (int k = 0; k < 40; k++) begin
            cyc = 0;
            while (exp_q.size() - rx_q.size() > DEPTH - 4 && cyc < 2 * BYTE_CYC) begin
                idle_cycles(1);   // keep well below capacity
                cyc++;
            end
            check_true(cyc < 2 * BYTE_CYC, "timeout waiting for queue space");
            drive_cycle(1'($urandom_range(1)), 8'($urandom),
                        1'($urandom_range(1)), 8'($urandom), 1'b1);
            idle_cycles(1 + $urandom_range(5));
        end
        idle_cycles(3);
        wait_drained(exp_q.size(), (DEPTH + 2) * BYTE_CYC);
        check_stream();
        end_test("random");

        for (int k = 0; k < 24; k++) begin
            d = 8'($urandom);
            burst.push_back(d);
            drive_cycle(1'b1, d, 1'b0, 8'h00, 1'b0);
        end
        idle_cycles(3);
        m_ovr[0] = (24 > DEPTH + 2);   // more than holding, FIFO and shifter
        wait_drained(DEPTH, (DEPTH + 4) * BYTE_CYC);
        check_true(rx_q.size() >= DEPTH, $sformatf("only %0d burst bytes received", rx_q.size()));
        bi       = 0;
        in_order = 1'b1;
        foreach (rx_q[i]) begin
            while (bi < burst.size() && burst[bi] != rx_q[i]) begin
                bi++;
            end
            in_order &= (bi < burst.size());
            bi++;
        end
        check_true(in_order, "burst bytes received out of order or repeated");
        check_val("txd first byte", burst[0], rx_q[0]);
        // drain is far slower than the burst, so the first DEPTH + 2 bytes get in
        check_val("txd last byte", burst[DEPTH + 1], rx_q[rx_q.size() - 1]);
        end_test("burst");

        drive_cycle(1'b0, 8'h00, 1'b1, 8'($urandom), 1'b1);
        idle_cycles(3);
        cyc = 0;
        while (rx_q.size() < 1 && cyc < 2 * BYTE_CYC) begin
            @(posedge clk_bus);
            cyc++;
        end
        check_true(rx_q.size() == 1, "timeout waiting for the last byte");
        cyc = 0;
        while (busy && cyc < 30) begin   // stop bit tail plus done crossing
            @(posedge clk_bus);
            cyc++;
        end
        check_true(!busy, "busy still high 30 cycles after the last byte");
        bi = 0;
        repeat (100) begin
            @(posedge clk_bus);
            if (txd !== 1'b1 || busy) begin
                bi++;
            end
        end
        check_val("txd low or busy cycles", 0, bi);
        check_stream();
        end_test("drain");

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
uart_pkg.sv
tx_arbiter.sv
tx_fifo.sv
uart_tx.sv
uart_tx_top.sv
tb_serial_sink.sv
tb_uart_tx_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_uart_tx_top
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^TB PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
